// ==== sources.f ====
+incdir+hdl
hdl/shm_pkg.sv
hdl/debouncer.sv
hdl/step_gen.sv
hdl/proc_mem.sv
hdl/dma_engine.sv
hdl/hex_display.sv
hdl/shm_test.sv
testbench/tb_shm_test.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the shm_test testbench with Verilator and runs it into sim.log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f sources.f \
	--top-module tb_shm_test \
	-o tb_shm_test

./obj_dir/tb_shm_test > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

echo "Simulation finished without failure"

// ==== testbench/tb_shm_test.sv ====
`timescale 1ns/1ns
`include "shm_defines.svh"

module tb_shm_test
	import shm_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 200000;       // Covers about 60 commands plus presses
	localparam int RANDOM_CMDS    = 40;

	logic        clk_28 = 1'b0;
	logic        rst_n;
	logic        step_key_n;                      // Low while pressed
	logic        auto_step;
	logic        start;
	dma_cmd_t    cmd;
	mem_addr_t   dbg_addr;
	logic        ack;
	logic        busy;
	mem_addr_t   ptr_out;
	mem_word_t   dbg_data;
	seg7_t [3:0] hex;

	mem_word_t   model_mem [`SHM_DEPTH];          // Reference copy of proc memory
	mem_addr_t   exp_ptr;                         // Expected ptr_out
	logic [31:0] rng = 32'd71;                    // xorshift state
	int          err_cnt   = 0;
	int          hex_errs  = 0;
	int          ack_cnt   = 0;                   // Every ack pulse seen
	int          tests_bad = 0;
	int          cycle_cnt = 0;

	shm_test dut_i (.*);

	always #20 clk_28 = ~clk_28;                  // 40 ns period

	always @(negedge clk_28) begin
		if (ack === 1'b1) begin
			ack_cnt++;                            // One count per pulse
		end
	end

	// Run limit
	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk_28);
			cycle_cnt++;
		end
		$display("Timeout: the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	// ========================================
	// Helpers
	// ========================================

	function automatic logic [31:0] next_rand();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	// Lit segments in gfedcba order then inverted for the active low pins
	function automatic seg7_t segments_for(input logic [3:0] nib);
		logic [6:0] lit;
		case (nib)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;                    // b and c only
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;                    // Everything
			4'h9: lit = 7'h6F;
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;                 // F
		endcase
		return ~lit;
	endfunction

	task automatic show_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("MISMATCH at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp, act);
		err_cnt++;
	endtask

	task automatic expect_acks(input int since, input int want, input string when);
		if (ack_cnt - since != want) begin
			$display("Wrong number of ack pulses %s: wanted %0d, saw %0d",
				when, want, ack_cnt - since);
			err_cnt++;
		end
	endtask

	task automatic finish_test(input int num, input string name, input int errs);
		if (errs == 0) begin
			$display("test %0d %s: passed", num, name);
		end else begin
			$display("test %0d %s: %0d errors", num, name, errs);
			tests_bad++;
		end
	endtask

	// Sequential loop so overlap and wrap follow word order
	task automatic apply_model(input dma_cmd_t c);
		mem_addr_t s;
		mem_addr_t d;
		for (int i = 0; i <= int'(c.len); i++) begin
			s = c.src + mem_addr_t'(i);
			d = c.dst + mem_addr_t'(i);
			if (c.action == ACT_COPY) begin
				model_mem[d] = model_mem[s];
			end else if (c.action == ACT_FILL) begin
				model_mem[d] = c.fill_value;
			end
		end
		if (c.action == ACT_COPY || c.action == ACT_FILL) begin
			exp_ptr = c.dst + c.len;              // Last word written
		end
	endtask

	task automatic issue_cmd(input dma_cmd_t c);
		@(negedge clk_28);
		cmd   = c;
		start = 1'b1;                             // Rising edge launches
		@(negedge clk_28);
		start = 1'b0;
	endtask

	task automatic wait_for_ack();
		while (ack !== 1'b1) begin
			@(negedge clk_28);
		end
		if (busy !== 1'b0) begin
			show_mismatch("busy", 32'd0, 32'(busy));
		end
		if (ptr_out !== exp_ptr) begin
			show_mismatch("ptr_out", 32'(exp_ptr), 32'(ptr_out));
		end
	endtask

	// Debug port read with data one clock after the address
	task automatic verify_memory(input logic with_hex);
		seg7_t exp_seg;
		for (int a = 0; a < `SHM_DEPTH; a++) begin
			@(negedge clk_28);
			dbg_addr = mem_addr_t'(a);
			@(negedge clk_28);
			if (dbg_data !== model_mem[a]) begin
				show_mismatch($sformatf("dbg_data[%0d]", a), 32'(model_mem[a]), 32'(dbg_data));
			end
			for (int d = 0; d < 4 && with_hex; d++) begin
				exp_seg = segments_for(model_mem[a][d*4 +: 4]);
				if (hex[d] !== exp_seg) begin
					show_mismatch($sformatf("hex[%0d]", d), 32'(exp_seg), 32'(hex[d]));
					hex_errs++;
				end
			end
		end
	endtask

	task automatic run_cmd(input dma_cmd_t c, input logic with_hex);
		issue_cmd(c);
		apply_model(c);
		wait_for_ack();
		verify_memory(with_hex);
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		dma_cmd_t    c;
		mem_addr_t   want;
		int          acks0;
		int          errs0;
		logic [31:0] r;
		rst_n      = 1'b0;
		step_key_n = 1'b1;                        // Released
		auto_step  = 1'b1;
		start      = 1'b0;
		cmd        = '0;
		dbg_addr   = '0;
		exp_ptr    = '0;
		repeat (5) @(negedge clk_28);
		rst_n = 1'b1;
		if (ack !== 1'b0) begin
			show_mismatch("ack", 32'd0, 32'(ack));
		end
		if (busy !== 1'b0) begin
			show_mismatch("busy", 32'd0, 32'(busy));
		end
		if (ptr_out !== '0) begin
			show_mismatch("ptr_out", 32'd0, 32'(ptr_out));
		end

		errs0 = err_cnt;                          // Whole memory fill seeds the model
		r = next_rand();
		c = '{action: ACT_FILL, src: '0, dst: '0, len: 4'hF, fill_value: r[15:0]};
		run_cmd(c, 1'b1);
		finish_test(1, "fill all memory", err_cnt - errs0);

		errs0 = err_cnt;
		for (int n = 0; n < RANDOM_CMDS; n++) begin
			r = next_rand();
			c.action     = r[12] ? ACT_COPY : ACT_FILL;
			c.src        = r[3:0];
			c.dst        = r[7:4];
			c.len        = r[11:8];
			c.fill_value = r[31:16];
			run_cmd(c, 1'b1);
		end
		finish_test(2, "random copy and fill", err_cnt - errs0);
		finish_test(4, "hex display", hex_errs);

		errs0 = err_cnt;                          // Second start edge while busy
		acks0 = ack_cnt;
		r = next_rand();
		c = '{action: ACT_COPY, src: r[3:0], dst: r[7:4], len: 4'hF, fill_value: r[31:16]};
		issue_cmd(c);
		apply_model(c);
		repeat (3) @(negedge clk_28);
		if (busy !== 1'b1) begin
			show_mismatch("busy", 32'd1, 32'(busy));
		end
		c.action = ACT_FILL;
		c.dst    = c.dst + 4'd5;
		issue_cmd(c);                             // Must be dropped
		wait_for_ack();
		repeat (100) @(negedge clk_28);
		expect_acks(acks0, 1, "for a start edge while busy");
		verify_memory(1'b0);
		acks0 = ack_cnt;
		c.action = ACT_IDLE;
		run_cmd(c, 1'b0);
		repeat (20) @(negedge clk_28);
		expect_acks(acks0, 1, "for an idle command");
		finish_test(3, "busy handling", err_cnt - errs0);

		errs0 = err_cnt;                          // Manual steps from the button
		@(negedge clk_28);
		auto_step = 1'b0;
		r = next_rand();
		c = '{action: ACT_FILL, src: '0, dst: exp_ptr + 4'd1, len: 4'd3, fill_value: r[15:0]};
		acks0 = ack_cnt;
		issue_cmd(c);
		apply_model(c);
		for (int k = 0; k < 4; k++) begin
			step_key_n = 1'b0;                    // Short glitch
			repeat (1 + int'(next_rand() % 32'(`SHM_DEBOUNCE_CYCLES - 1))) @(negedge clk_28);
			step_key_n = 1'b1;
			repeat (20) @(negedge clk_28);
			want = c.dst + mem_addr_t'(k) - 4'd1;
			if (ptr_out !== want) begin
				show_mismatch("ptr_out", 32'(want), 32'(ptr_out));
			end
			expect_acks(acks0, 0, "after a glitch");
			step_key_n = 1'b0;                    // Clean press
			repeat (20) @(negedge clk_28);
			step_key_n = 1'b1;
			repeat (20) @(negedge clk_28);
			want = c.dst + mem_addr_t'(k);
			if (ptr_out !== want) begin
				show_mismatch("ptr_out", 32'(want), 32'(ptr_out));
			end
			expect_acks(acks0, (k == 3) ? 1 : 0, $sformatf("after press %0d", k + 1));
		end
		verify_memory(1'b0);
		finish_test(5, "manual stepping", err_cnt - errs0);

		$display("Summary: 5 tests, %0d with errors, %0d errors in total", tests_bad, err_cnt);
		if (err_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== hdl/shm_test.sv ====
`timescale 1ns/1ns

module shm_test
	import shm_pkg::*;
(
	input  logic        clk_28,
	input  logic        rst_n,
	input  logic        step_key_n,               // Step button, low pressed
	input  logic        auto_step,                // 1 steps from the prescaler
	input  logic        start,                    // Rising edge issues cmd
	input  dma_cmd_t    cmd,
	input  mem_addr_t   dbg_addr,                 // Debug read address
	output logic        ack,
	output logic        busy,
	output mem_addr_t   ptr_out,
	output mem_word_t   dbg_data,                 // Word at dbg_addr, one clock late
	output seg7_t [3:0] hex                       // Display of dbg_data
);

	logic      step_en;                           // Engine advance enable
	mem_req_t  mem_req;                           // Engine to port A
	mem_word_t mem_rdata;                         // Port A to engine

	// ========================================
	// Step source
	// ========================================

	step_gen step_gen_i (
		.clk_28     (clk_28),
		.rst_n      (rst_n),
		.step_key_n (step_key_n),
		.auto_step  (auto_step),
		.step_en    (step_en)
	);

	// ========================================
	// Engine and memory
	// ========================================

	dma_engine dma_i (
		.clk_28  (clk_28),
		.rst_n   (rst_n),
		.step_en (step_en),
		.start   (start),
		.cmd     (cmd),
		.req     (mem_req),
		.rdata   (mem_rdata),
		.ack     (ack),
		.busy    (busy),
		.ptr_out (ptr_out)
	);

	proc_mem mem_i (
		.clk_28   (clk_28),
		.req      (mem_req),
		.rdata    (mem_rdata),
		.dbg_addr (dbg_addr),
		.dbg_data (dbg_data)
	);

	// ========================================
	// Display
	// ========================================

	hex_display hex_i (
		.word (dbg_data),
		.hex  (hex)
	);

endmodule

// ==== hdl/hex_display.sv ====
`timescale 1ns/1ns

module hex_display
	import shm_pkg::*;
(
	input  mem_word_t   word,                     // Debug word
	output seg7_t [3:0] hex                       // Digit 0 is the low nibble
);

	// ========================================
	// Nibble to segments, active low
	// ========================================

	function automatic seg7_t nib_to_seg(input logic [3:0] nib);
		seg7_t seg;
		case (nib)
			4'h0: seg = 7'h40;                    // All but g
			4'h1: seg = 7'h79;
			4'h2: seg = 7'h24;
			4'h3: seg = 7'h30;
			4'h4: seg = 7'h19;
			4'h5: seg = 7'h12;
			4'h6: seg = 7'h02;
			4'h7: seg = 7'h78;
			4'h8: seg = 7'h00;                    // All seven lit
			4'h9: seg = 7'h10;
			4'hA: seg = 7'h08;
			4'hB: seg = 7'h03;                    // Lower case b
			4'hC: seg = 7'h46;
			4'hD: seg = 7'h21;                    // Lower case d
			4'hE: seg = 7'h06;
			default: seg = 7'h0E;                 // F
		endcase
		return seg;
	endfunction

	always_comb begin
		for (int d = 0; d < 4; d++) begin
			hex[d] = nib_to_seg(word[d*4 +: 4]);  // One digit per nibble
		end
	end

endmodule

// ==== hdl/dma_engine.sv ====
`timescale 1ns/1ns
`include "shm_defines.svh"

module dma_engine
	import shm_pkg::*;
(
	input  logic      clk_28,
	input  logic      rst_n,
	input  logic      step_en,                    // Advance enable
	input  logic      start,                      // Level, rising edge launches
	input  dma_cmd_t  cmd,                        // Sampled on launch
	output mem_req_t  req,                        // To memory port A
	input  mem_word_t rdata,                      // From memory port A
	output logic      ack,                        // One cycle done pulse
	output logic      busy,                       // Command in flight
	output mem_addr_t ptr_out                     // Last word written
);

	dma_state_e state;                            // Engine FSM
	dma_cmd_t   cmd_q;                            // Latched command
	logic       start_q;                          // Start delayed one clock
	logic       launch;                           // Accepted start edge
	logic       last_word;                        // Word counter at len
	logic [`SHM_ADDR_W-1:0] idx;                  // Word counter
	mem_addr_t  src_addr;
	mem_addr_t  dst_addr;

	// ========================================
	// Launch and addressing
	// ========================================

	assign launch    = start & ~start_q & ~busy;  // Edges while busy are dropped
	assign last_word = (idx == cmd_q.len);
	assign src_addr  = cmd_q.src + idx;           // Wraps mod 16
	assign dst_addr  = cmd_q.dst + idx;

	assign busy = (state == ST_READ) || (state == ST_WRITE);
	assign ack  = (state == ST_DONE);             // Busy falls in the same cycle

	always_ff @(posedge clk_28 or negedge rst_n) begin
		if (!rst_n) begin
			start_q <= 1'b0;
		end else begin
			start_q <= start;
		end
	end

	// ========================================
	// Memory request
	// ========================================

	// Source address is held outside the write step so rdata stays current
	always_comb begin
		req.addr  = src_addr;
		req.wdata = (cmd_q.action == ACT_FILL) ? cmd_q.fill_value : rdata;
		req.we    = 1'b0;
		if (state == ST_WRITE && step_en) begin
			req.addr = dst_addr;
			req.we   = 1'b1;                      // Write on the step only
		end
	end

	// ========================================
	// Copy and fill FSM
	// ========================================

	always_ff @(posedge clk_28 or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			ptr_out <= '0;
			idx     <= '0;
		end else begin
			case (state)
				ST_READ: begin
					if (step_en) begin
						state <= ST_WRITE;        // rdata valid next clock
					end
				end
				ST_WRITE: begin
					if (step_en) begin
						ptr_out <= dst_addr;
						if (last_word) begin
							state <= ST_DONE;
						end else begin
							idx   <= idx + 1'b1;
							state <= (cmd_q.action == ACT_COPY) ? ST_READ : ST_WRITE;
						end
					end
				end
				ST_DONE: begin
					state <= ST_IDLE;             // Single ack cycle
				end
				default: ;
			endcase

			// Launch happens only in idle or done where nothing above is lost
			if (launch) begin
				idx <= '0;
				case (cmd.action)
					ACT_COPY: state <= ST_READ;
					ACT_FILL: state <= ST_WRITE;  // No read needed
					default:  state <= ST_DONE;   // Ack without a write
				endcase
			end
		end
	end

	// Command payload register
	always_ff @(posedge clk_28) begin
		if (launch) begin
			cmd_q <= cmd;
		end
	end

endmodule

// ==== hdl/proc_mem.sv ====
`timescale 1ns/1ns
`include "shm_defines.svh"

module proc_mem
	import shm_pkg::*;
(
	input  logic      clk_28,
	input  mem_req_t  req,                        // Engine port A
	output mem_word_t rdata,                      // Port A read, one clock late
	input  mem_addr_t dbg_addr,                   // Debug port B address
	output mem_word_t dbg_data                    // Port B read, one clock late
);

	mem_word_t mem [`SHM_DEPTH];                  // Word array, no reset

	// ========================================
	// Port A
	// ========================================

	always_ff @(posedge clk_28) begin
		if (req.we) begin
			mem[req.addr] <= req.wdata;           // Write on strobe
		end
		rdata <= mem[req.addr];                   // Old data on a write cycle
	end

	// ========================================
	// Port B
	// ========================================

	always_ff @(posedge clk_28) begin
		dbg_data <= mem[dbg_addr];                // Read only
	end

endmodule

// ==== hdl/step_gen.sv ====
`timescale 1ns/1ns
`include "shm_defines.svh"

module step_gen (
	input  logic clk_28,
	input  logic rst_n,
	input  logic step_key_n,                      // Manual step button
	input  logic auto_step,                       // 1 picks the prescaler
	output logic step_en                          // Single cycle step enable
);

	localparam int DIV_W = $clog2(`SHM_STEP_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SHM_STEP_DIV - 1);

	logic [DIV_W-1:0] div_cnt;                    // Prescaler count
	logic tick;                                   // Auto step pulse
	logic press;                                  // Debounced manual step

	// ========================================
	// Manual source
	// ========================================

	debouncer key_db_i (
		.clk_28 (clk_28),
		.rst_n  (rst_n),
		.key_n  (step_key_n),
		.press  (press)
	);

	// ========================================
	// Auto source
	// ========================================

	always_ff @(posedge clk_28 or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end else if (div_cnt == DIV_LAST) begin
			div_cnt <= '0;                        // Wrap every SHM_STEP_DIV clocks
			tick    <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			tick    <= 1'b0;
		end
	end

	// Clock enable instead of a muxed clock
	assign step_en = auto_step ? tick : press;    // Both inputs are flops

endmodule

// ==== hdl/debouncer.sv ====
`timescale 1ns/1ns
`include "shm_defines.svh"

module debouncer (
	input  logic clk_28,
	input  logic rst_n,
	input  logic key_n,                           // Raw button, low when pressed
	output logic press                            // One pulse per accepted press
);

	localparam int CNT_W = $clog2(`SHM_DEBOUNCE_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SHM_DEBOUNCE_CYCLES - 1);

	logic sync1_n;                                // First sync stage
	logic sync2_n;                                // Second sync stage
	logic stable_n;                               // Accepted button level
	logic [CNT_W-1:0] cnt;                        // Cycles at the new level

	// ========================================
	// Two flop synchroniser
	// ========================================

	always_ff @(posedge clk_28 or negedge rst_n) begin
		if (!rst_n) begin
			sync1_n <= 1'b1;                      // Released
			sync2_n <= 1'b1;
		end else begin
			sync1_n <= key_n;
			sync2_n <= sync1_n;
		end
	end

	// ========================================
	// Hold counter and press pulse
	// ========================================

	always_ff @(posedge clk_28 or negedge rst_n) begin
		if (!rst_n) begin
			stable_n <= 1'b1;
			cnt      <= '0;
			press    <= 1'b0;
		end else begin
			press <= 1'b0;                        // Pulse by default low
			if (sync2_n == stable_n) begin
				cnt <= '0;                        // Glitch gone, start over
			end else if (cnt == CNT_LAST) begin
				stable_n <= sync2_n;              // New level accepted
				cnt      <= '0;
				press    <= ~sync2_n;             // Only the released to pressed edge
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

// ==== hdl/shm_pkg.sv ====
`include "shm_defines.svh"

package shm_pkg;

	// ========================================
	// Plain vectors
	// ========================================

	typedef logic [`SHM_ADDR_W-1:0] mem_addr_t;   // Word address into proc memory
	typedef logic [`SHM_DATA_W-1:0] mem_word_t;   // One memory word
	typedef logic [6:0] seg7_t;                   // Active low, bit 0 is segment a

	// ========================================
	// DMA command
	// ========================================

	typedef enum logic [1:0] {
		ACT_IDLE = 2'd0,                          // No operation, ack only
		ACT_COPY = 2'd1,                          // Block copy src to dst
		ACT_FILL = 2'd2,                          // Block fill with constant
		ACT_RSVD = 2'd3                           // Treated like idle
	} dma_action_e;

	typedef struct packed {
		dma_action_e             action;          // What to do
		mem_addr_t               src;             // First source word
		mem_addr_t               dst;             // First destination word
		logic [`SHM_ADDR_W-1:0]  len;             // Word count minus one
		mem_word_t               fill_value;      // Constant for fill
	} dma_cmd_t;

	// Engine request to memory port A
	typedef struct packed {
		mem_addr_t  addr;                         // Read or write address
		mem_word_t  wdata;                        // Write data
		logic       we;                           // Write strobe
	} mem_req_t;

	// Engine FSM, kept here with the other types
	typedef enum logic [1:0] {
		ST_IDLE,                                  // Waiting for start
		ST_READ,                                  // Copy read step
		ST_WRITE,                                 // Write step
		ST_DONE                                   // Ack cycle
	} dma_state_e;

endpackage

// ==== hdl/shm_defines.svh ====
`ifndef SHM_DEFINES_SVH
`define SHM_DEFINES_SVH

// ========================================
// Processor memory geometry
// ========================================

`define SHM_ADDR_W 4          // Word address bits
`define SHM_DEPTH 16          // Words in the processor memory
`define SHM_DATA_W 16         // Bits per memory word

// ========================================
// Step clocking
// ========================================

// Cycles the synchronised button must sit at a new level before it counts
`define SHM_DEBOUNCE_CYCLES 8

// Auto mode step period in clk_28 cycles
`define SHM_STEP_DIV 4

`endif
